// File: logic/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    // register files
    localparam int ARCH_REGS = 16;
    localparam int AREG_W    = 4;
    localparam int PHYS_REGS = 32;
    localparam int PREG_W    = 5;

    // queues
    localparam int ROB_SIZE   = 16;
    localparam int ROB_IDX_W  = 4;
    localparam int ROB_CNT_W  = ROB_IDX_W + 1;
    localparam int IBUF_DEPTH = 8;
    localparam int IBUF_PTR_W = 3;
    localparam int IBUF_CNT_W = IBUF_PTR_W + 1;

    // instruction word layout: op | rd | rs1 | rs2
    localparam int PC_W    = 16;
    localparam int INST_W  = 16;
    localparam int OP_W    = 4;
    localparam int OP_LSB  = 12;
    localparam int RD_LSB  = 8;
    localparam int RS1_LSB = 4;
    localparam int RS2_LSB = 0;

    // arch reg i sits in phys reg i out of reset, upper half free
    localparam logic [PHYS_REGS-1:0] INIT_FREE_MASK =
        {{(PHYS_REGS - ARCH_REGS){1'b1}}, {ARCH_REGS{1'b0}}};

    typedef enum logic [OP_W-1:0] {
        op_nop   = 4'h0,
        op_alu   = 4'h1,
        op_load  = 4'h2,
        op_store = 4'h3
    } opcode_e;

    typedef struct packed {
        logic [INST_W-1:0] inst;
        logic [PC_W-1:0]   pc;
    } fetch_entry_t;

    typedef struct packed {
        opcode_e           op;
        logic [AREG_W-1:0] rd;
        logic [AREG_W-1:0] rs1;
        logic [AREG_W-1:0] rs2;
        logic              writes_rd;
        logic              illegal;
        logic [PC_W-1:0]   pc;
    } dec_info_t;

    typedef struct packed {
        opcode_e           op;
        logic [AREG_W-1:0] rd;
        logic [PREG_W-1:0] prd;
        logic [PREG_W-1:0] old_prd;
        logic [PREG_W-1:0] prs1;
        logic [PREG_W-1:0] prs2;
        logic              writes_rd;
        logic              illegal;
        logic [PC_W-1:0]   pc;
    } rename_info_t;

    typedef struct packed {
        logic [ROB_IDX_W-1:0] rob_idx;
        opcode_e              op;
        logic [PREG_W-1:0]    prd;
        logic [PREG_W-1:0]    prs1;
        logic [PREG_W-1:0]    prs2;
    } disp_info_t;

    typedef struct packed {
        logic [ROB_IDX_W-1:0] rob_idx;
        logic [AREG_W-1:0]    rd;
        logic [PREG_W-1:0]    prd;
        logic [PREG_W-1:0]    old_prd;
        logic                 writes_rd;
        logic [PC_W-1:0]      pc;
    } commit_info_t;

    typedef struct packed {
        logic [PC_W-1:0]      pc;
        logic [ROB_IDX_W-1:0] rob_idx;
    } squash_info_t;

endpackage

`default_nettype wire

// File: logic/inst_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module inst_buffer (
    input  logic                   clk,
    input  logic                   i_rst,
    input  logic                   i_flush,
    input  logic                   i_enq_vld,
    input  ctrl_pkg::fetch_entry_t i_enq,
    output logic                   o_full,
    output logic                   o_deq_vld,
    output ctrl_pkg::fetch_entry_t o_deq,
    input  logic                   i_deq
);
    import ctrl_pkg::*;

    fetch_entry_t          mem [IBUF_DEPTH];
    logic [IBUF_PTR_W-1:0] wr_ptr;
    logic [IBUF_PTR_W-1:0] rd_ptr;
    logic [IBUF_CNT_W-1:0] count;
    logic                  do_enq;
    logic                  do_deq;

    assign o_full    = (count == IBUF_CNT_W'(IBUF_DEPTH));
    assign o_deq_vld = (count != '0);
    assign o_deq     = mem[rd_ptr];

    // writes are dropped while full
    assign do_enq = i_enq_vld && !o_full;
    assign do_deq = i_deq && o_deq_vld;

    always_ff @(posedge clk) begin
        if (i_rst || i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_deq) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_enq, do_deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem[wr_ptr] <= i_enq;
        end
    end

endmodule

`default_nettype wire

// File: logic/decode.sv
`timescale 1ns/10ps
`default_nettype none

module decode (
    input  logic                   clk,
    input  logic                   i_rst,
    input  logic                   i_flush,
    input  logic                   i_inst_vld,
    input  ctrl_pkg::fetch_entry_t i_inst,
    output logic                   o_pop,
    input  logic                   i_stall,
    output logic                   o_dec_vld,
    output ctrl_pkg::dec_info_t    o_dec
);
    import ctrl_pkg::*;

    dec_info_t dec_next;
    logic      stage_free;

    // register empties or is taken by rename this cycle
    assign stage_free = !o_dec_vld || !i_stall;
    assign o_pop      = i_inst_vld && stage_free;

    always_comb begin
        dec_next.op        = opcode_e'(i_inst.inst[OP_LSB +: OP_W]);
        dec_next.rd        = i_inst.inst[RD_LSB +: AREG_W];
        dec_next.rs1       = i_inst.inst[RS1_LSB +: AREG_W];
        dec_next.rs2       = i_inst.inst[RS2_LSB +: AREG_W];
        dec_next.pc        = i_inst.pc;
        dec_next.writes_rd = 1'b0;
        dec_next.illegal   = 1'b0;
        case (dec_next.op)
            op_alu, op_load: begin
                dec_next.writes_rd = 1'b1;
            end
            op_nop, op_store: begin
                dec_next.writes_rd = 1'b0;
            end
            default: begin
                // unknown encoding, carried to the rob as a fault
                dec_next.illegal = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst || i_flush) begin
            o_dec_vld <= 1'b0;
        end else if (stage_free) begin
            o_dec_vld <= i_inst_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (o_pop) begin
            o_dec <= dec_next;
        end
    end

endmodule

`default_nettype wire

// File: logic/rename.sv
`timescale 1ns/10ps
`default_nettype none

module rename (
    input  logic                   clk,
    input  logic                   i_rst,
    input  logic                   i_flush,
    input  logic                   i_dec_vld,
    input  ctrl_pkg::dec_info_t    i_dec,
    output logic                   o_stall,
    input  logic                   i_rob_ready,
    output logic                   o_ren_vld,
    output ctrl_pkg::rename_info_t o_ren,
    input  logic                   i_commit_vld,
    input  ctrl_pkg::commit_info_t i_commit
);
    import ctrl_pkg::*;

    // speculative state, rolled back on squash
    logic [PREG_W-1:0]    spec_map [ARCH_REGS];
    logic [PHYS_REGS-1:0] spec_free;
    // committed state
    logic [PREG_W-1:0]    cmt_map [ARCH_REGS];
    logic [PHYS_REGS-1:0] cmt_free;

    logic [PREG_W-1:0] alloc_prd;
    logic              have_free;
    logic              out_free;
    logic              accept;
    logic              do_alloc;
    logic              do_free;
    rename_info_t      ren_next;

    // lowest numbered free register wins
    always_comb begin
        have_free = 1'b0;
        alloc_prd = '0;
        for (int i = PHYS_REGS - 1; i >= 0; i--) begin
            if (spec_free[i]) begin
                have_free = 1'b1;
                alloc_prd = PREG_W'(i);
            end
        end
    end

    assign out_free = !o_ren_vld || i_rob_ready;
    assign o_stall  = !out_free || (i_dec_vld && i_dec.writes_rd && !have_free);
    assign accept   = i_dec_vld && !o_stall;
    assign do_alloc = accept && i_dec.writes_rd;
    assign do_free  = i_commit_vld && i_commit.writes_rd;

    always_comb begin
        ren_next.op        = i_dec.op;
        ren_next.rd        = i_dec.rd;
        ren_next.prd       = i_dec.writes_rd ? alloc_prd : '0;
        ren_next.old_prd   = i_dec.writes_rd ? spec_map[i_dec.rd] : '0;
        ren_next.prs1      = spec_map[i_dec.rs1];
        ren_next.prs2      = spec_map[i_dec.rs2];
        ren_next.writes_rd = i_dec.writes_rd;
        ren_next.illegal   = i_dec.illegal;
        ren_next.pc        = i_dec.pc;
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                spec_map[i] <= PREG_W'(i);
            end
            spec_free <= INIT_FREE_MASK;
        end else if (i_flush) begin
            spec_map  <= cmt_map;
            spec_free <= cmt_free;
        end else begin
            if (do_alloc) begin
                spec_map[i_dec.rd]   <= alloc_prd;
                spec_free[alloc_prd] <= 1'b0;
            end
            // old_prd is still live, so never equal to alloc_prd
            if (do_free) begin
                spec_free[i_commit.old_prd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                cmt_map[i] <= PREG_W'(i);
            end
            cmt_free <= INIT_FREE_MASK;
        end else if (do_free) begin
            cmt_map[i_commit.rd]       <= i_commit.prd;
            cmt_free[i_commit.old_prd] <= 1'b1;
            cmt_free[i_commit.prd]     <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst || i_flush) begin
            o_ren_vld <= 1'b0;
        end else if (out_free) begin
            o_ren_vld <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_ren <= ren_next;
        end
    end

endmodule

`default_nettype wire

// File: logic/rob.sv
`timescale 1ns/10ps
`default_nettype none

module rob (
    input  logic                           clk,
    input  logic                           i_rst,
    input  logic                           i_ren_vld,
    input  ctrl_pkg::rename_info_t         i_ren,
    output logic                           o_ready,
    output logic                           o_disp_vld,
    output ctrl_pkg::disp_info_t           o_disp,
    input  logic                           i_wb_vld,
    input  logic [ctrl_pkg::ROB_IDX_W-1:0] i_wb_rob_idx,
    output logic                           o_commit_vld,
    output ctrl_pkg::commit_info_t         o_commit,
    output logic                           o_squash_vld,
    output ctrl_pkg::squash_info_t         o_squash
);
    import ctrl_pkg::*;

    rename_info_t         ent [ROB_SIZE];
    logic [ROB_SIZE-1:0]  ent_vld;
    logic [ROB_SIZE-1:0]  ent_done;
    logic [ROB_IDX_W-1:0] head;
    logic [ROB_IDX_W-1:0] tail;
    logic [ROB_CNT_W-1:0] count;
    rename_info_t         head_ent;
    logic                 head_vld;
    logic                 enq;
    logic                 no_exec;

    assign head_ent = ent[head];
    assign head_vld = ent_vld[head];

    // faulting head flushes instead of committing
    assign o_squash_vld = head_vld && head_ent.illegal;
    assign o_commit_vld = head_vld && ent_done[head] && !head_ent.illegal;

    // no enqueue on the squash edge
    assign o_ready = (count != ROB_CNT_W'(ROB_SIZE)) && !o_squash_vld;
    assign enq     = i_ren_vld && o_ready;

    // nops and faults never go to execution
    assign no_exec    = i_ren.illegal || (i_ren.op == op_nop);
    assign o_disp_vld = enq && !no_exec;

    always_comb begin
        o_disp.rob_idx = tail;
        o_disp.op      = i_ren.op;
        o_disp.prd     = i_ren.prd;
        o_disp.prs1    = i_ren.prs1;
        o_disp.prs2    = i_ren.prs2;
    end

    always_comb begin
        o_commit.rob_idx   = head;
        o_commit.rd        = head_ent.rd;
        o_commit.prd       = head_ent.prd;
        o_commit.old_prd   = head_ent.old_prd;
        o_commit.writes_rd = head_ent.writes_rd;
        o_commit.pc        = head_ent.pc;
        o_squash.pc        = head_ent.pc;
        o_squash.rob_idx   = head;
    end

    always_ff @(posedge clk) begin
        if (i_rst || o_squash_vld) begin
            ent_vld  <= '0;
            ent_done <= '0;
            head     <= '0;
            tail     <= '0;
            count    <= '0;
        end else begin
            if (i_wb_vld && ent_vld[i_wb_rob_idx]) begin
                ent_done[i_wb_rob_idx] <= 1'b1;
            end
            if (enq) begin
                ent_vld[tail]  <= 1'b1;
                ent_done[tail] <= no_exec;
                tail           <= tail + 1'b1;
            end
            // retire the head slot
            if (o_commit_vld) begin
                ent_vld[head]  <= 1'b0;
                ent_done[head] <= 1'b0;
                head           <= head + 1'b1;
            end
            case ({enq, o_commit_vld})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (enq) begin
            ent[tail] <= i_ren;
        end
    end

endmodule

`default_nettype wire

// File: logic/ctrl_block.sv
`timescale 1ns/10ps
`default_nettype none

// fetch -> inst_buffer -> decode -> rename -> rob
module ctrl_block (
    input  logic                           clk,
    input  logic                           i_rst,
    input  logic                           i_inst_vld,
    input  ctrl_pkg::fetch_entry_t         i_inst,
    output logic                           o_stall,
    output logic                           o_disp_vld,
    output ctrl_pkg::disp_info_t           o_disp,
    input  logic                           i_wb_vld,
    input  logic [ctrl_pkg::ROB_IDX_W-1:0] i_wb_rob_idx,
    output logic                           o_commit_vld,
    output ctrl_pkg::commit_info_t         o_commit,
    output logic                           o_squash_vld,
    output ctrl_pkg::squash_info_t         o_squash
);
    import ctrl_pkg::*;

    fetch_entry_t ibuf_entry;
    logic         ibuf_vld;
    logic         dec_pop;
    dec_info_t    dec_info;
    logic         dec_vld;
    logic         ren_stall;
    rename_info_t ren_info;
    logic         ren_vld;
    logic         rob_ready;

    inst_buffer u_inst_buffer (
        .clk      (clk),
        .i_rst    (i_rst),
        .i_flush  (o_squash_vld),
        .i_enq_vld(i_inst_vld),
        .i_enq    (i_inst),
        .o_full   (o_stall),
        .o_deq_vld(ibuf_vld),
        .o_deq    (ibuf_entry),
        .i_deq    (dec_pop)
    );

    decode u_decode (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_flush   (o_squash_vld),
        .i_inst_vld(ibuf_vld),
        .i_inst    (ibuf_entry),
        .o_pop     (dec_pop),
        .i_stall   (ren_stall),
        .o_dec_vld (dec_vld),
        .o_dec     (dec_info)
    );

    rename u_rename (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_flush     (o_squash_vld),
        .i_dec_vld   (dec_vld),
        .i_dec       (dec_info),
        .o_stall     (ren_stall),
        .i_rob_ready (rob_ready),
        .o_ren_vld   (ren_vld),
        .o_ren       (ren_info),
        .i_commit_vld(o_commit_vld),
        .i_commit    (o_commit)
    );

    rob u_rob (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_ren_vld   (ren_vld),
        .i_ren       (ren_info),
        .o_ready     (rob_ready),
        .o_disp_vld  (o_disp_vld),
        .o_disp      (o_disp),
        .i_wb_vld    (i_wb_vld),
        .i_wb_rob_idx(i_wb_rob_idx),
        .o_commit_vld(o_commit_vld),
        .o_commit    (o_commit),
        .o_squash_vld(o_squash_vld),
        .o_squash    (o_squash)
    );

endmodule

`default_nettype wire

// File: test/ctrl_block_tb.sv
`timescale 1ns/10ps
`default_nettype none

module ctrl_block_tb;
    import ctrl_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int N_INSTS      = 400;
    localparam int CYC_PER_INST = 20;
    // writeback rate flips between fast and slow every this many fetches
    localparam int PHASE_LEN    = 60;

    // one accepted instruction as the model tracks it
    typedef struct packed {
        logic [PC_W-1:0]      pc;
        logic [OP_W-1:0]      op;
        logic [AREG_W-1:0]    rd;
        logic [AREG_W-1:0]    rs1;
        logic [AREG_W-1:0]    rs2;
        logic                 illegal;
        logic                 writes_rd;
        logic [PREG_W-1:0]    prd;
        logic [ROB_IDX_W-1:0] rob_idx;
    } model_rec_t;

    logic                 clk = 1'b0;
    logic                 i_rst;
    logic                 i_inst_vld;
    fetch_entry_t         i_inst;
    logic                 o_stall;
    logic                 o_disp_vld;
    disp_info_t           o_disp;
    logic                 i_wb_vld;
    logic [ROB_IDX_W-1:0] i_wb_rob_idx;
    logic                 o_commit_vld;
    commit_info_t         o_commit;
    logic                 o_squash_vld;
    squash_info_t         o_squash;

    integer seed           = 57;
    int     errors         = 0;
    int     issued         = 0;
    int     n_commit       = 0;
    int     n_squash       = 0;
    int     disp_pos       = 0;
    logic   rst_checked    = 1'b0;
    logic   first_prd_seen = 1'b0;
    logic   drained        = 1'b0;

    // rob slot the next accepted instruction lands in
    logic [ROB_IDX_W-1:0] next_rob_idx = '0;

    // program order, oldest first; disp_pos marks the next one to dispatch
    model_rec_t           prog_q [$];
    logic [PREG_W-1:0]    spec_map [ARCH_REGS];
    logic [PREG_W-1:0]    cmt_map [ARCH_REGS];
    logic [ROB_IDX_W-1:0] wb_list [$];

    ctrl_block DUT (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_inst_vld  (i_inst_vld),
        .i_inst      (i_inst),
        .o_stall     (o_stall),
        .o_disp_vld  (o_disp_vld),
        .o_disp      (o_disp),
        .i_wb_vld    (i_wb_vld),
        .i_wb_rob_idx(i_wb_rob_idx),
        .o_commit_vld(o_commit_vld),
        .o_commit    (o_commit),
        .o_squash_vld(o_squash_vld),
        .o_squash    (o_squash)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("[ERROR] %0t %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        errors++;
    endtask

    task automatic report_fault(input string msg);
        $display("error at %0t: %s", $time, msg);
        errors++;
    endtask

    function automatic fetch_entry_t make_inst(input logic [PC_W-1:0] pc);
        fetch_entry_t    e;
        logic [OP_W-1:0] op;
        op = OP_W'($random(seed));
        // about one in twenty lands outside the four defined opcodes
        if (($random(seed) % 20) == 0) begin
            op[2] = 1'b1;
        end else begin
            op[3:2] = 2'b00;
        end
        e.inst = {op, (INST_W - OP_W)'($random(seed))};
        e.pc   = pc;
        return e;
    endfunction

    function automatic model_rec_t make_rec(input fetch_entry_t e,
                                            input logic [ROB_IDX_W-1:0] idx);
        model_rec_t rec;
        rec.pc        = e.pc;
        rec.op        = e.inst[OP_LSB +: OP_W];
        rec.rd        = e.inst[RD_LSB +: AREG_W];
        rec.rs1       = e.inst[RS1_LSB +: AREG_W];
        rec.rs2       = e.inst[RS2_LSB +: AREG_W];
        rec.illegal   = !(rec.op inside {op_nop, op_alu, op_load, op_store});
        rec.writes_rd = (rec.op == op_alu) || (rec.op == op_load);
        rec.prd       = '0;
        rec.rob_idx   = idx;
        return rec;
    endfunction

    function automatic logic is_live(input logic [PREG_W-1:0] p);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < ARCH_REGS; i++) begin
            if (spec_map[i] == p || cmt_map[i] == p) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic check_dispatch();
        model_rec_t rec;
        // nops and faults enter the rob without a dispatch
        while (disp_pos < prog_q.size() && (prog_q[disp_pos].illegal ||
               prog_q[disp_pos].op == op_nop)) begin
            disp_pos++;
        end
        if (disp_pos >= prog_q.size()) begin
            report_fault("dispatch with no matching instruction in flight");
        end else begin
            rec = prog_q[disp_pos];
            assert (o_disp.rob_idx == rec.rob_idx)
                else report_value("o_disp.rob_idx", 32'(o_disp.rob_idx), 32'(rec.rob_idx));
            assert (o_disp.op == rec.op)
                else report_value("o_disp.op", 32'(o_disp.op), 32'(rec.op));
            assert (o_disp.prs1 == spec_map[rec.rs1])
                else report_value("o_disp.prs1", 32'(o_disp.prs1), 32'(spec_map[rec.rs1]));
            assert (o_disp.prs2 == spec_map[rec.rs2])
                else report_value("o_disp.prs2", 32'(o_disp.prs2), 32'(spec_map[rec.rs2]));
            if (rec.writes_rd) begin
                assert (!is_live(o_disp.prd))
                    else report_fault("dispatched prd is still mapped to a register");
                if (!first_prd_seen) begin
                    assert (o_disp.prd == PREG_W'(ARCH_REGS))
                        else report_value("o_disp.prd", 32'(o_disp.prd), ARCH_REGS);
                    first_prd_seen = 1'b1;
                end
                spec_map[rec.rd] = o_disp.prd;
            end else begin
                assert (o_disp.prd == '0) else report_value("o_disp.prd", 32'(o_disp.prd), 0);
            end
            rec.prd = o_disp.prd;
            prog_q[disp_pos] = rec;
            disp_pos++;
            wb_list.push_back(rec.rob_idx);
        end
    endtask

    task automatic check_commit();
        model_rec_t rec;
        if (prog_q.size() == 0) begin
            report_fault("commit with no instruction outstanding");
        end else begin
            rec = prog_q.pop_front();
            assert (o_commit.pc == rec.pc)
                else report_value("o_commit.pc", 32'(o_commit.pc), 32'(rec.pc));
            assert (o_commit.rob_idx == rec.rob_idx)
                else report_value("o_commit.rob_idx", 32'(o_commit.rob_idx),
                                  32'(rec.rob_idx));
            assert (o_commit.rd == rec.rd)
                else report_value("o_commit.rd", 32'(o_commit.rd), 32'(rec.rd));
            assert (!rec.illegal) else report_fault("an illegal instruction committed");
            assert (o_commit.writes_rd == rec.writes_rd)
                else report_value("o_commit.writes_rd", 32'(o_commit.writes_rd), 32'(rec.writes_rd));
            if (disp_pos > 0) begin
                disp_pos--;
            end else begin
                assert (rec.op == op_nop) else report_fault("instruction committed before dispatch");
            end
            if (rec.writes_rd) begin
                assert (o_commit.prd == rec.prd)
                    else report_value("o_commit.prd", 32'(o_commit.prd), 32'(rec.prd));
                assert (o_commit.old_prd == cmt_map[rec.rd])
                    else report_value("o_commit.old_prd", 32'(o_commit.old_prd),
                                      32'(cmt_map[rec.rd]));
                cmt_map[rec.rd] = rec.prd;
            end
            n_commit++;
        end
    endtask

    task automatic check_squash();
        if (prog_q.size() == 0) begin
            report_fault("squash with no instruction outstanding");
        end else begin
            assert (prog_q[0].illegal) else report_fault("squash raised by a legal instruction");
            assert (o_squash.pc == prog_q[0].pc)
                else report_value("o_squash.pc", 32'(o_squash.pc), 32'(prog_q[0].pc));
            assert (o_squash.rob_idx == prog_q[0].rob_idx)
                else report_value("o_squash.rob_idx", 32'(o_squash.rob_idx),
                                  32'(prog_q[0].rob_idx));
        end
        // everything in flight is gone, speculation rolls back
        prog_q.delete();
        wb_list.delete();
        disp_pos     = 0;
        next_rob_idx = '0;
        spec_map     = cmt_map;
        n_squash++;
    endtask

    always @(posedge clk) begin
        logic accepted;
        logic wb_now;
        int   k;
        if (!i_rst) begin
            if (!rst_checked) begin
                assert (!o_disp_vld && !o_commit_vld && !o_squash_vld && !o_stall)
                    else report_fault("a strobe or the stall is high right after reset");
                rst_checked = 1'b1;
            end
            // a fetch on the squash edge is flushed with the rest
            accepted = i_inst_vld && !o_stall && !o_squash_vld;
            if (o_squash_vld) begin
                check_squash();
            end else begin
                if (o_commit_vld) begin
                    check_commit();
                end
                if (o_disp_vld) begin
                    check_dispatch();
                end
            end
            if (accepted) begin
                prog_q.push_back(make_rec(i_inst, next_rob_idx));
                next_rob_idx = next_rob_idx + 1'b1;
                issued++;
            end

            if (o_squash_vld) begin
                i_inst <= make_inst(o_squash.pc + PC_W'(1));
            end else if (accepted) begin
                i_inst <= make_inst(i_inst.pc + PC_W'(1));
            end
            i_inst_vld <= (issued < N_INSTS) && (($random(seed) & 3) != 0);

            // slow phases let the rob fill up
            if ((issued / PHASE_LEN) % 2 == 1) begin
                wb_now = ($random(seed) & 15) == 0;
            end else begin
                wb_now = ($random(seed) & 3) != 0;
            end
            i_wb_vld <= 1'b0;
            if (wb_now && wb_list.size() > 0) begin
                k = ($random(seed) & 32'h7fff_ffff) % wb_list.size();
                i_wb_vld     <= 1'b1;
                i_wb_rob_idx <= wb_list[k];
                wb_list.delete(k);
            end

            if (issued >= N_INSTS && prog_q.size() == 0) begin
                drained = 1'b1;
            end
        end
    end

    initial begin
        for (int i = 0; i < ARCH_REGS; i++) begin
            spec_map[i] = PREG_W'(i);
            cmt_map[i]  = PREG_W'(i);
        end
        i_rst        <= 1'b1;
        i_inst_vld   <= 1'b0;
        i_inst       <= make_inst('0);
        i_wb_vld     <= 1'b0;
        i_wb_rob_idx <= '0;
        repeat (5) @(posedge clk);
        i_rst <= 1'b0;
        wait (drained);
        repeat (2) @(posedge clk);
        $display("commits %0d, squashes %0d, errors %0d", n_commit, n_squash, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(N_INSTS * CYC_PER_INST * CLK_PERIOD);
        $display("watchdog expired with %0d instructions still in flight", prog_q.size());
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
logic/ctrl_pkg.sv
logic/inst_buffer.sv
logic/decode.sv
logic/rename.sv
logic/rob.sv
logic/ctrl_block.sv
test/ctrl_block_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module ctrl_block_tb -Mdir obj_dir -o ctrl_block_tb

run: compile
	./obj_dir/ctrl_block_tb | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
